// ==== design/ih_settings.svh ====
// Input front end constants
// PS/2 scan codes, download indices, PLL management words and bus widths

`ifndef IH_SETTINGS_SVH
`define IH_SETTINGS_SVH

// PS/2 set 2 scan codes for the cabinet buttons
`define IH_KEY_START1   8'h16
`define IH_KEY_START2   8'h1E
`define IH_KEY_COIN1    8'h2E
`define IH_KEY_COIN2    8'h36
`define IH_KEY_SERVICE  8'h46
`define IH_KEY_UP       8'h75
`define IH_KEY_DOWN     8'h72
`define IH_KEY_LEFT     8'h6B
`define IH_KEY_RIGHT    8'h74
`define IH_KEY_B1       8'h14
`define IH_KEY_B2       8'h11
`define IH_KEY_B3       8'h29

// Download stream
`define IH_IDX_HEADER   8'd1
`define IH_IDX_DIP      8'd254
`define IH_DIP_BYTES    3
`define IH_ADDR_W       25

// PLL reconfiguration, management addresses and fractional words
`define IH_PLL_ADDR_MODE    6'd0
`define IH_PLL_ADDR_MFRAC   6'd7
`define IH_PLL_ADDR_START   6'd2
`define IH_PLL_FRAC_NATIVE  32'd3639383488
`define IH_PLL_FRAC_UNDER   32'd2977614927
`define IH_PLL_FRAC_BOOTLEG 32'd2748778984

// Word widths
`define IH_JOY_W        16
`define IH_PS2_W        11

`endif

// ==== design/ih_pkg.sv ====
// Input front end types
// Joystick word with its USB and DB15 decodings, player control bundle
// and the PLL rate selection

`include "ih_settings.svh"

package ih_pkg;

	// USB pad layout, bit 0 is right
	typedef struct packed {
		logic [`IH_JOY_W-12:0] spare;
		logic pause;
		logic start2;
		logic coin;
		logic start1;
		logic b3;
		logic b2;
		logic b1;
		logic up;
		logic down;
		logic left;
		logic right;
	} joy_usb_t;

	// DB15 user-port layout as delivered by the port mixer
	typedef struct packed {
		logic [`IH_JOY_W-13:0] rsv_hi;
		logic db_mode;
		logic db_start;
		logic db_select;
		logic [1:0] rsv_mid;
		// Directions and buttons, same order as USB
		logic [6:0] pad;
	} joy_db15_t;

	// Same 16 bits, two readings
	typedef union packed {
		joy_usb_t  usb;
		joy_db15_t db;
	} joy_word_u;

	// One player's controls, active high
	typedef struct packed {
		logic up;
		logic down;
		logic left;
		logic right;
		logic b1;
		logic b2;
		logic b3;
	} player_ctrl_t;

	// Applied PLL rate
	typedef enum logic [1:0] {
		RATE_NATIVE  = 2'd0,
		RATE_UNDER   = 2'd1,
		RATE_BOOTLEG = 2'd2
	} rate_sel_t;

endpackage

// ==== design/ih_ifaces.sv ====
// Input front end interfaces
// Keyboard button levels and the two players' cabinet controls

`timescale 1ns/1ps

//==========================================================================
// Keyboard buttons, held levels from the PS/2 decoder
//==========================================================================
interface kbd_if;
	logic start1;
	logic start2;
	logic coin1;
	logic coin2;
	logic service;
	logic up;
	logic down;
	logic left;
	logic right;
	logic b1;
	logic b2;
	logic b3;

	modport src (output start1, start2, coin1, coin2, service,
		output up, down, left, right, b1, b2, b3);
	modport dst (input start1, start2, coin1, coin2, service,
		input up, down, left, right, b1, b2, b3);
endinterface

//==========================================================================
// Cabinet controls, active high, inverted at the top
//==========================================================================
interface ctrl_if import ih_pkg::*; ();
	player_ctrl_t p1;
	player_ctrl_t p2;
	// Bit 0 player 1, bit 1 player 2
	logic [1:0] start;
	logic [1:0] coin;
	logic service;
	logic pause;

	modport src (output p1, p2, start, coin, service, pause);
	modport dst (input p1, p2, start, coin, service, pause);
endinterface

// ==== design/ps2_button_decoder.sv ====
// PS/2 button decoder
// Turns key make/break events into held cabinet button levels

`timescale 1ns/1ps
`include "ih_settings.svh"

module ps2_button_decoder (
	input  logic                 CLK_49M,
	input  logic                 reset,
	input  logic [`IH_PS2_W-1:0] ps2_key,
	kbd_if.src                   kbd
);

	// Bit 10 toggles per event, bit 9 is the press flag
	logic       strobe_q;
	logic       key_event;
	logic       pressed;
	logic [7:0] code;
	logic [11:0] btn_all;

	assign key_event = (strobe_q != ps2_key[10]);
	assign pressed   = ps2_key[9];
	assign code      = ps2_key[7:0];

	always_ff @(posedge CLK_49M) begin
		if (reset) begin
			strobe_q    <= 1'b0;
			kbd.start1  <= 1'b0;
			kbd.start2  <= 1'b0;
			kbd.coin1   <= 1'b0;
			kbd.coin2   <= 1'b0;
			kbd.service <= 1'b0;
			kbd.up      <= 1'b0;
			kbd.down    <= 1'b0;
			kbd.left    <= 1'b0;
			kbd.right   <= 1'b0;
			kbd.b1      <= 1'b0;
			kbd.b2      <= 1'b0;
			kbd.b3      <= 1'b0;
		end else begin
			strobe_q <= ps2_key[10];
			if (key_event) begin
				case (code)
					// Keys 1, 2, 5, 6, 9
					`IH_KEY_START1:  kbd.start1  <= pressed;
					`IH_KEY_START2:  kbd.start2  <= pressed;
					`IH_KEY_COIN1:   kbd.coin1   <= pressed;
					`IH_KEY_COIN2:   kbd.coin2   <= pressed;
					`IH_KEY_SERVICE: kbd.service <= pressed;
					// Cursor keys
					`IH_KEY_UP:      kbd.up      <= pressed;
					`IH_KEY_DOWN:    kbd.down    <= pressed;
					`IH_KEY_LEFT:    kbd.left    <= pressed;
					`IH_KEY_RIGHT:   kbd.right   <= pressed;
					// Ctrl, alt, space
					`IH_KEY_B1:      kbd.b1      <= pressed;
					`IH_KEY_B2:      kbd.b2      <= pressed;
					`IH_KEY_B3:      kbd.b3      <= pressed;
					// Anything else leaves the levels alone
					default: ;
				endcase
			end
		end
	end

	assign btn_all = {kbd.start1, kbd.start2, kbd.coin1, kbd.coin2, kbd.service,
		kbd.up, kbd.down, kbd.left, kbd.right, kbd.b1, kbd.b2, kbd.b3};

	// Levels only move on a strobe edge
	a_no_spurious_level: assert property (@(posedge CLK_49M) disable iff (reset)
		!key_event |=> $stable(btn_all));

endmodule

// ==== design/rom_option_capture.sv ====
// ROM option capture
// Picks the bootleg and Japan flags from the ROM header and keeps the
// DIP switch bytes sent in the download stream

`timescale 1ns/1ps
`include "ih_settings.svh"

module rom_option_capture (
	input  logic                        CLK_49M,
	input  logic                        reset,
	input  logic                        ioctl_wr,
	input  logic [7:0]                  ioctl_index,
	input  logic [`IH_ADDR_W-1:0]       ioctl_addr,
	input  logic [7:0]                  ioctl_dout,
	output logic [1:0]                  is_bootleg,
	output logic                        is_japan,
	output logic [8*`IH_DIP_BYTES-1:0]  dip_bytes
);

	// Stored as written, the top inverts to active low
	logic [7:0] dip_q [`IH_DIP_BYTES];
	logic       hdr_wr;
	logic       dip_wr;

	// Header flags live in the first byte of index 1
	assign hdr_wr = ioctl_wr && (ioctl_index == `IH_IDX_HEADER) && (ioctl_addr == '0);

	// Only the low three DIP bytes are kept
	assign dip_wr = ioctl_wr && (ioctl_index == `IH_IDX_DIP)
		&& (ioctl_addr[`IH_ADDR_W-1:3] == '0)
		&& (ioctl_addr[2:0] < 3'(`IH_DIP_BYTES));

	always_ff @(posedge CLK_49M) begin
		if (reset) begin
			is_bootleg <= 2'b00;
			is_japan   <= 1'b0;
			for (int i = 0; i < `IH_DIP_BYTES; i++) begin
				dip_q[i] <= 8'h00;
			end
		end else begin
			if (hdr_wr) begin
				// Bits 1:0 board variant, bit 4 Japanese set
				is_bootleg <= ioctl_dout[1:0];
				is_japan   <= ioctl_dout[4];
			end
			if (dip_wr) begin
				dip_q[ioctl_addr[1:0]] <= ioctl_dout;
			end
		end
	end

	// Byte 0 lands lowest
	for (genvar i = 0; i < `IH_DIP_BYTES; i++) begin : g_pack
		assign dip_bytes[8*i +: 8] = dip_q[i];
	end

endmodule

// ==== design/joystick_router.sv ====
// Joystick router
// Chooses USB or DB15 pads per player, remaps DB15 words, merges in the
// keyboard and applies the Japanese button 3 swap

`timescale 1ns/1ps

module joystick_router import ih_pkg::*; (
	input  logic      CLK_49M,
	input  logic      reset,
	input  joy_word_u joy_usb_0,
	input  joy_word_u joy_usb_1,
	input  joy_word_u joydb_1,
	input  joy_word_u joydb_2,
	input  logic      joydb_1ena,
	input  logic      joydb_2ena,
	input  logic      is_japan,
	kbd_if.dst        kbd,
	ctrl_if.src       ctrl
);

	joy_word_u    pad0;
	joy_word_u    pad1;
	joy_word_u    pads_or;
	player_ctrl_t kbd_pc;
	player_ctrl_t p1_next;
	player_ctrl_t p2_next;

	// DB15 to USB layout
	// swap_start picks which DB15 key acts as start 1
	function automatic joy_word_u db15_remap(input joy_word_u raw, input logic swap_start);
		joy_word_u m;
		m = '0;
		m.db.pad     = raw.db.pad;
		// Mode, or start held with button 2, drops a coin
		m.usb.coin   = raw.db.db_mode | (raw.db.db_start & raw.db.pad[5]);
		m.usb.start1 = swap_start ? raw.db.db_select : raw.db.db_start;
		m.usb.start2 = swap_start ? raw.db.db_start : raw.db.db_select;
		return m;
	endfunction

	// Player bits of a pad word, with b3 given from outside
	function automatic player_ctrl_t pad_ctrl(input joy_word_u w, input logic b3);
		player_ctrl_t c;
		c.up    = w.usb.up;
		c.down  = w.usb.down;
		c.left  = w.usb.left;
		c.right = w.usb.right;
		c.b1    = w.usb.b1;
		c.b2    = w.usb.b2;
		c.b3    = b3;
		return c;
	endfunction

	//======================================================================
	// Source selection
	//======================================================================
	// With only DB15 port 1 in use, USB pad 0 moves to player 2
	assign pad0 = joydb_1ena ? db15_remap(joydb_1, 1'b0) : joy_usb_0;
	assign pad1 = joydb_2ena ? db15_remap(joydb_2, 1'b1)
		: (joydb_1ena ? joy_usb_0 : joy_usb_1);
	assign pads_or = pad0 | pad1;

	// Keyboard drives both players
	assign kbd_pc = '{up: kbd.up, down: kbd.down, left: kbd.left, right: kbd.right,
		b1: kbd.b1, b2: kbd.b2, b3: kbd.b3};

	// Japanese set reads button 3 from the other player's pad
	assign p1_next = kbd_pc | pad_ctrl(pad0, is_japan ? pad1.usb.b3 : pad0.usb.b3);
	assign p2_next = kbd_pc | pad_ctrl(pad1, is_japan ? pad0.usb.b3 : pad1.usb.b3);

	//======================================================================
	// Output register
	//======================================================================
	always_ff @(posedge CLK_49M) begin
		if (reset) begin
			ctrl.p1      <= '0;
			ctrl.p2      <= '0;
			ctrl.start   <= 2'b00;
			ctrl.coin    <= 2'b00;
			ctrl.service <= 1'b0;
			ctrl.pause   <= 1'b0;
		end else begin
			ctrl.p1    <= p1_next;
			ctrl.p2    <= p2_next;
			ctrl.start <= {kbd.start2 | pads_or.usb.start2, kbd.start1 | pads_or.usb.start1};
			// Coin 2 is keyboard only
			ctrl.coin  <= {kbd.coin2, kbd.coin1 | pads_or.usb.coin};
			ctrl.service <= kbd.service;
			ctrl.pause   <= pads_or.usb.pause;
		end
	end

endmodule

// ==== design/pll_rate_sequencer.sv ====
// PLL rate sequencer
// Watches the underclock and bootleg settings and rewrites the PLL
// fractional divider through three management writes

`timescale 1ns/1ps
`include "ih_settings.svh"

module pll_rate_sequencer import ih_pkg::*; (
	input  logic        CLK_49M,
	input  logic        reset,
	input  logic        underclock,
	input  logic [1:0]  is_bootleg,
	input  logic        cfg_waitrequest,
	output logic        cfg_write,
	output logic [5:0]  cfg_address,
	output logic [31:0] cfg_data
);

	// Two-stage filters for both rate inputs
	logic       uc_s1;
	logic       uc_s2;
	logic       bl_s1;
	logic       bl_s2;
	// Last values written to the PLL
	logic       uc_r;
	logic       bl_r;
	logic       uc_change;
	logic       bl_change;
	logic       restart;
	logic [2:0] step;
	rate_sel_t  applied_sel;
	logic [31:0] frac_word;
	logic        wr_now;
	logic [5:0]  wr_addr;
	logic [31:0] wr_data;

	assign uc_change = (uc_s2 == uc_s1) && (uc_s2 != uc_r);
	assign bl_change = (bl_s2 == bl_s1) && (bl_s2 != bl_r);
	assign restart   = uc_change || bl_change;

	// Bootleg board wins over underclock
	assign applied_sel = bl_r ? RATE_BOOTLEG : (uc_r ? RATE_UNDER : RATE_NATIVE);

	always_comb begin
		case (applied_sel)
			RATE_BOOTLEG: frac_word = `IH_PLL_FRAC_BOOTLEG;
			RATE_UNDER:   frac_word = `IH_PLL_FRAC_UNDER;
			default:      frac_word = `IH_PLL_FRAC_NATIVE;
		endcase
	end

	//======================================================================
	// Write schedule on steps 1, 5 and 7 of the count
	//======================================================================
	always_comb begin
		wr_now  = 1'b0;
		wr_addr = `IH_PLL_ADDR_MODE;
		wr_data = 32'd0;
		if (!restart && !cfg_waitrequest) begin
			case (step)
				3'd1: wr_now = 1'b1;
				3'd5: begin
					wr_now  = 1'b1;
					wr_addr = `IH_PLL_ADDR_MFRAC;
					wr_data = frac_word;
				end
				3'd7: begin
					wr_now  = 1'b1;
					wr_addr = `IH_PLL_ADDR_START;
				end
				default: ;
			endcase
		end
	end

	always_ff @(posedge CLK_49M) begin
		if (reset) begin
			uc_s1     <= 1'b0;
			uc_s2     <= 1'b0;
			bl_s1     <= 1'b0;
			bl_s2     <= 1'b0;
			uc_r      <= 1'b0;
			bl_r      <= 1'b0;
			step      <= 3'd0;
			cfg_write <= 1'b0;
		end else begin
			uc_s1 <= underclock;
			uc_s2 <= uc_s1;
			bl_s1 <= (is_bootleg == 2'b10);
			bl_s2 <= bl_s1;
			if (uc_change) uc_r <= uc_s2;
			if (bl_change) bl_r <= bl_s2;
			cfg_write <= wr_now;
			// A new change starts over from the mode word
			if (restart)
				step <= 3'd1;
			else if (!cfg_waitrequest && step != 3'd0)
				step <= step + 3'd1;
		end
	end

	// Address and data held from the last write
	always_ff @(posedge CLK_49M) begin
		if (reset) begin
			cfg_address <= `IH_PLL_ADDR_MODE;
			cfg_data    <= 32'd0;
		end else if (wr_now) begin
			cfg_address <= wr_addr;
			cfg_data    <= wr_data;
		end
	end

	// Writes go to known registers
	a_cfg_addr: assert property (@(posedge CLK_49M) disable iff (reset)
		cfg_write |-> (cfg_address inside {`IH_PLL_ADDR_MODE, `IH_PLL_ADDR_MFRAC,
			`IH_PLL_ADDR_START}));

endmodule

// ==== design/ih_input_top.sv ====
// Iron Horse input front end
// Keyboard, joystick routing, ROM options and PLL rate control
// presented as active-low cabinet signals

`timescale 1ns/1ps
`include "ih_settings.svh"

module ih_input_top (
	input  logic                        CLK_49M,
	input  logic                        reset,
	// Keyboard and pads
	input  logic [`IH_PS2_W-1:0]        ps2_key,
	input  logic [`IH_JOY_W-1:0]        joy_usb_0,
	input  logic [`IH_JOY_W-1:0]        joy_usb_1,
	input  logic [`IH_JOY_W-1:0]        joydb_1,
	input  logic [`IH_JOY_W-1:0]        joydb_2,
	input  logic                        joydb_1ena,
	input  logic                        joydb_2ena,
	// Download stream
	input  logic                        ioctl_wr,
	input  logic [7:0]                  ioctl_index,
	input  logic [`IH_ADDR_W-1:0]       ioctl_addr,
	input  logic [7:0]                  ioctl_dout,
	// PLL management
	input  logic                        underclock,
	input  logic                        cfg_waitrequest,
	output logic                        cfg_write,
	output logic [5:0]                  cfg_address,
	output logic [31:0]                 cfg_data,
	// Cabinet side, active low
	output logic [3:0]                  p1_joystick,
	output logic [3:0]                  p2_joystick,
	output logic [2:0]                  p1_buttons,
	output logic [2:0]                  p2_buttons,
	output logic [1:0]                  btn_start,
	output logic [1:0]                  coin,
	output logic                        btn_service,
	output logic                        pause_request,
	output logic [8*`IH_DIP_BYTES-1:0]  dipsw,
	output logic [1:0]                  is_bootleg
);

	logic                       is_japan;
	logic [8*`IH_DIP_BYTES-1:0] dip_bytes;

	kbd_if  kbd_bus ();
	ctrl_if ctrl_bus ();

	//======================================================================
	// Input side
	//======================================================================
	ps2_button_decoder u_kbd (
		.CLK_49M (CLK_49M),
		.reset   (reset),
		.ps2_key (ps2_key),
		.kbd     (kbd_bus.src)
	);

	rom_option_capture u_opts (
		.CLK_49M     (CLK_49M),
		.reset       (reset),
		.ioctl_wr    (ioctl_wr),
		.ioctl_index (ioctl_index),
		.ioctl_addr  (ioctl_addr),
		.ioctl_dout  (ioctl_dout),
		.is_bootleg  (is_bootleg),
		.is_japan    (is_japan),
		.dip_bytes   (dip_bytes)
	);

	// Pad selection and merge
	joystick_router u_router (
		.CLK_49M    (CLK_49M),
		.reset      (reset),
		.joy_usb_0  (joy_usb_0),
		.joy_usb_1  (joy_usb_1),
		.joydb_1    (joydb_1),
		.joydb_2    (joydb_2),
		.joydb_1ena (joydb_1ena),
		.joydb_2ena (joydb_2ena),
		.is_japan   (is_japan),
		.kbd        (kbd_bus.dst),
		.ctrl       (ctrl_bus.src)
	);

	pll_rate_sequencer u_pll_seq (
		.CLK_49M         (CLK_49M),
		.reset           (reset),
		.underclock      (underclock),
		.is_bootleg      (is_bootleg),
		.cfg_waitrequest (cfg_waitrequest),
		.cfg_write       (cfg_write),
		.cfg_address     (cfg_address),
		.cfg_data        (cfg_data)
	);

	//======================================================================
	// Cabinet outputs
	//======================================================================
	// Joystick order is down, up, right, left
	assign p1_joystick = ~{ctrl_bus.p1.down, ctrl_bus.p1.up, ctrl_bus.p1.right, ctrl_bus.p1.left};
	assign p2_joystick = ~{ctrl_bus.p2.down, ctrl_bus.p2.up, ctrl_bus.p2.right, ctrl_bus.p2.left};
	assign p1_buttons  = ~{ctrl_bus.p1.b3, ctrl_bus.p1.b2, ctrl_bus.p1.b1};
	assign p2_buttons  = ~{ctrl_bus.p2.b3, ctrl_bus.p2.b2, ctrl_bus.p2.b1};
	assign btn_start   = ~ctrl_bus.start;
	assign coin        = ~ctrl_bus.coin;
	assign btn_service = ~ctrl_bus.service;
	// Pause stays active high
	assign pause_request = ctrl_bus.pause;
	// DIP switches are active low on the board
	assign dipsw = ~dip_bytes;

endmodule

// ==== sim/tb_ih_inputs.sv ====
// Testbench for the input front end
// Random key events, pads and download writes against a cycle model,
// then PLL rate changes under random management stalls

`timescale 1ns/1ps
`include "ih_settings.svh"

module tb_ih_inputs import ih_pkg::*; ();

	typedef logic [8*`IH_DIP_BYTES-1:0] dip_word_t;
	typedef struct packed {
		logic [5:0]  addr;
		logic [31:0] data;
	} cfg_wr_t;

	logic CLK_49M = 1'b0;
	logic reset;
	logic [`IH_PS2_W-1:0] ps2_key;
	logic [`IH_JOY_W-1:0] joy_usb_0;
	logic [`IH_JOY_W-1:0] joy_usb_1;
	logic [`IH_JOY_W-1:0] joydb_1;
	logic [`IH_JOY_W-1:0] joydb_2;
	logic joydb_1ena;
	logic joydb_2ena;
	logic ioctl_wr;
	logic [7:0] ioctl_index;
	logic [`IH_ADDR_W-1:0] ioctl_addr;
	logic [7:0] ioctl_dout;
	logic underclock;
	logic cfg_waitrequest;
	logic cfg_write;
	logic [5:0] cfg_address;
	logic [31:0] cfg_data;
	logic [3:0] p1_joystick;
	logic [3:0] p2_joystick;
	logic [2:0] p1_buttons;
	logic [2:0] p2_buttons;
	logic [1:0] btn_start;
	logic [1:0] coin;
	logic btn_service;
	logic pause_request;
	dip_word_t dipsw;
	logic [1:0] is_bootleg;

	// Scan code table in index order start1 to b3
	localparam logic [7:0] key_code [12] = '{`IH_KEY_START1, `IH_KEY_START2,
		`IH_KEY_COIN1, `IH_KEY_COIN2, `IH_KEY_SERVICE, `IH_KEY_UP, `IH_KEY_DOWN,
		`IH_KEY_LEFT, `IH_KEY_RIGHT, `IH_KEY_B1, `IH_KEY_B2, `IH_KEY_B3};

	// Model state holds register values after the last edge
	logic [11:0]  kb;
	logic         strobe_m;
	logic         japan_m;
	logic [1:0]   bootleg_m;
	logic [7:0]   dip_m [`IH_DIP_BYTES];
	player_ctrl_t exp_p1;
	player_ctrl_t exp_p2;
	logic [1:0]   exp_start;
	logic [1:0]   exp_coin;
	logic         exp_service;
	logic         exp_pause;
	logic         uc_m;
	logic         bl_m;
	// Rate change bookkeeping
	logic         pll_window;
	cfg_wr_t      got_wr [$];
	logic [31:0]  rng;
	int checks;
	int ctrl_errors;
	int flag_errors;
	int dip_errors;
	int pll_errors;
	int timeouts;

	ih_input_top dut (.*);

	always #5 CLK_49M = ~CLK_49M;

	function automatic logic [31:0] rand32();
		rng = rng * 32'd1664525 + 32'd1013904223;
		return rng;
	endfunction

	//==========================================================================
	// Reference rules
	//==========================================================================
	// DB15 word into USB layout with start keys swapped on the second port
	function automatic logic [15:0] remap_db15(input logic [15:0] raw, input logic second);
		logic [15:0] m;
		m = 16'h0000;
		m[6:0] = raw[6:0];
		m[8] = raw[11] | (raw[10] & raw[5]);
		m[7] = second ? raw[9] : raw[10];
		m[9] = second ? raw[10] : raw[9];
		return m;
	endfunction

	function automatic player_ctrl_t pad_ctrl(input logic [15:0] w, input logic b3);
		return '{up: w[3], down: w[2], left: w[1], right: w[0], b1: w[4], b2: w[5], b3: b3};
	endfunction

	function automatic player_ctrl_t kbd_ctrl(input logic [11:0] k);
		return '{up: k[5], down: k[6], left: k[7], right: k[8], b1: k[9], b2: k[10], b3: k[11]};
	endfunction

	// Active-low cabinet pins back to active-high controls
	function automatic player_ctrl_t cabinet_ctrl(input logic [3:0] joy, input logic [2:0] btn);
		return '{up: ~joy[2], down: ~joy[3], left: ~joy[0], right: ~joy[1],
			b1: ~btn[0], b2: ~btn[1], b3: ~btn[2]};
	endfunction

	function automatic logic [31:0] frac_for(input rate_sel_t r);
		case (r)
			RATE_BOOTLEG: return `IH_PLL_FRAC_BOOTLEG;
			RATE_UNDER:   return `IH_PLL_FRAC_UNDER;
			default:      return `IH_PLL_FRAC_NATIVE;
		endcase
	endfunction

	// One clock edge of the model with the router first so it sees old levels
	task automatic model_edge();
		logic [15:0] w0;
		logic [15:0] w1;
		player_ctrl_t kc;
		kc = kbd_ctrl(kb);
		w0 = joydb_1ena ? remap_db15(joydb_1, 1'b0) : joy_usb_0;
		w1 = joydb_2ena ? remap_db15(joydb_2, 1'b1) : (joydb_1ena ? joy_usb_0 : joy_usb_1);
		exp_p1 = kc | pad_ctrl(w0, japan_m ? w1[6] : w0[6]);
		exp_p2 = kc | pad_ctrl(w1, japan_m ? w0[6] : w1[6]);
		exp_start = {kb[1] | w0[9] | w1[9], kb[0] | w0[7] | w1[7]};
		exp_coin = {kb[3], kb[2] | w0[8] | w1[8]};
		exp_service = kb[4];
		exp_pause = w0[10] | w1[10];
		// Key levels follow the strobe toggle
		if (ps2_key[10] != strobe_m) begin
			for (int k = 0; k < 12; k++) begin
				if (ps2_key[7:0] == key_code[k]) begin
					kb[k] = ps2_key[9];
				end
			end
		end
		strobe_m = ps2_key[10];
		if (ioctl_wr && ioctl_index == `IH_IDX_HEADER && ioctl_addr == '0) begin
			bootleg_m = ioctl_dout[1:0];
			japan_m = ioctl_dout[4];
		end
		if (ioctl_wr && ioctl_index == `IH_IDX_DIP && ioctl_addr[`IH_ADDR_W-1:3] == '0
			&& ioctl_addr[2:0] < 3'd3) begin
			dip_m[ioctl_addr[1:0]] = ioctl_dout;
		end
	endtask

	//==========================================================================
	// Compare tasks
	//==========================================================================
	task automatic check_ctrl(input string what, input player_ctrl_t got,
		input player_ctrl_t exp);
		checks++;
		if (got !== exp) begin
			ctrl_errors++;
			$display("Error at %t: %s controls %b, expected %b", $realtime, what, got, exp);
		end
	endtask

	// Bootleg bits, pause, service, coins, starts
	task automatic check_flags(input logic [7:0] got, input logic [7:0] exp);
		checks++;
		if (got !== exp) begin
			flag_errors++;
			$display("Error at %t: shared flags %b, expected %b", $realtime, got, exp);
		end
	endtask

	task automatic check_dip(input dip_word_t got, input dip_word_t exp);
		checks++;
		if (got !== exp) begin
			dip_errors++;
			$display("Error at %t: dipsw %h, expected %h", $realtime, got, exp);
		end
	endtask

	task automatic check_write(input int n, input cfg_wr_t got, input cfg_wr_t exp);
		checks++;
		if (got !== exp) begin
			pll_errors++;
			$display("Error at %t: PLL write %0d to %0d data %h, expected %0d data %h",
				$realtime, n, got.addr, got.data, exp.addr, exp.data);
		end
	endtask

	task automatic compare_outputs();
		check_ctrl("p1", cabinet_ctrl(p1_joystick, p1_buttons), exp_p1);
		check_ctrl("p2", cabinet_ctrl(p2_joystick, p2_buttons), exp_p2);
		check_flags({is_bootleg, pause_request, ~btn_service, ~coin, ~btn_start},
			{bootleg_m, exp_pause, exp_service, exp_coin, exp_start});
		check_dip(dipsw, ~{dip_m[2], dip_m[1], dip_m[0]});
	endtask

	//==========================================================================
	// Clocking and stimulus
	//==========================================================================
	// Edge, model, capture, compare, then drive the stall line
	task automatic step();
		logic [31:0] r;
		cfg_wr_t w;
		@(posedge CLK_49M);
		#1;
		model_edge();
		if (cfg_write) begin
			w.addr = cfg_address;
			w.data = cfg_data;
			if (pll_window) begin
				got_wr.push_back(w);
			end else begin
				pll_errors++;
				$display("Error at %t: cfg_write pulsed with no rate change", $realtime);
			end
		end
		compare_outputs();
		r = rand32();
		cfg_waitrequest = pll_window ? r[7] : 1'b0;
	endtask

	// Sparse words so merged bits still vary
	task automatic random_pads(input logic [1:0] ena);
		joy_usb_0 = 16'(rand32() & rand32());
		joy_usb_1 = 16'(rand32() & rand32());
		joydb_1 = 16'(rand32() & rand32());
		joydb_2 = 16'(rand32() & rand32());
		{joydb_2ena, joydb_1ena} = ena;
	endtask

	// Known codes most of the time and any byte otherwise
	task automatic random_key();
		logic [31:0] r;
		logic [3:0] k;
		r = rand32();
		k = 4'(r[4:0] % 5'd12);
		ps2_key[10] = ~ps2_key[10];
		ps2_key[9] = r[31];
		ps2_key[7:0] = (r[4:0] < 5'd24) ? key_code[k] : r[15:8];
	endtask

	task automatic header_write(input logic [7:0] dout);
		ioctl_wr = 1'b1;
		ioctl_index = `IH_IDX_HEADER;
		ioctl_addr = '0;
		ioctl_dout = dout;
		step();
		ioctl_wr = 1'b0;
	endtask

	// Toggle one rate input and collect the write sequence
	task automatic pll_change();
		logic [31:0] r;
		logic [1:0] bl_bits;
		cfg_wr_t exp_wr [3];
		int n;
		r = rand32();
		got_wr.delete();
		if (r[0]) begin
			underclock = ~underclock;
			uc_m = underclock;
			step();
		end else begin
			bl_m = ~bl_m;
			bl_bits = bl_m ? 2'b10 : ((r[2:1] == 2'b10) ? 2'b11 : r[2:1]);
			header_write({3'b000, japan_m, 2'b00, bl_bits});
		end
		n = 0;
		while (got_wr.size() < 3 && n < 200) begin
			step();
			n++;
		end
		if (got_wr.size() < 3) begin
			timeouts++;
			$display("Timeout: PLL write sequence not finished after 200 cycles");
		end
		// Quiet period with no fourth write
		repeat (30) step();
		if (got_wr.size() != 3) begin
			pll_errors++;
			$display("Error at %t: %0d PLL writes, expected 3", $realtime, got_wr.size());
		end
		exp_wr[0] = '{addr: `IH_PLL_ADDR_MODE, data: 32'd0};
		exp_wr[1] = '{addr: `IH_PLL_ADDR_MFRAC,
			data: frac_for(bl_m ? RATE_BOOTLEG : (uc_m ? RATE_UNDER : RATE_NATIVE))};
		exp_wr[2] = '{addr: `IH_PLL_ADDR_START, data: 32'd0};
		for (int k = 0; k < got_wr.size() && k < 3; k++) begin
			check_write(k, got_wr[k], exp_wr[k]);
		end
	endtask

	initial begin
		logic [31:0] r;
		logic [31:0] s;
		int total;
		$timeformat(-9, 0, " ns", 0);
		rng = 32'h5147_167c;
		reset = 1'b1;
		ps2_key = '0;
		joy_usb_0 = '0;
		joy_usb_1 = '0;
		joydb_1 = '0;
		joydb_2 = '0;
		joydb_1ena = 1'b0;
		joydb_2ena = 1'b0;
		ioctl_wr = 1'b0;
		ioctl_index = 8'd0;
		ioctl_addr = '0;
		ioctl_dout = 8'd0;
		underclock = 1'b0;
		cfg_waitrequest = 1'b0;
		kb = '0;
		strobe_m = 1'b0;
		japan_m = 1'b0;
		bootleg_m = 2'b00;
		for (int k = 0; k < `IH_DIP_BYTES; k++) begin
			dip_m[k] = 8'h00;
		end
		exp_p1 = '0;
		exp_p2 = '0;
		exp_start = 2'b00;
		exp_coin = 2'b00;
		exp_service = 1'b0;
		exp_pause = 1'b0;
		uc_m = 1'b0;
		bl_m = 1'b0;
		pll_window = 1'b0;
		checks = 0;
		ctrl_errors = 0;
		flag_errors = 0;
		dip_errors = 0;
		pll_errors = 0;
		timeouts = 0;

		repeat (5) @(posedge CLK_49M);
		#1;
		reset = 1'b0;
		// Reset values with everything inactive
		compare_outputs();
		check_flags({7'd0, cfg_write}, 8'd0);

		// Key events and pads while the enables walk all four combinations
		for (int i = 0; i < 600; i++) begin
			r = rand32();
			random_pads(2'(i / 16));
			if (r[0]) begin
				random_key();
			end
			step();
		end

		// Japanese set swaps button 3 between players
		header_write(8'h10);
		for (int i = 0; i < 300; i++) begin
			r = rand32();
			random_pads(2'(i / 8));
			if (r[1]) begin
				random_key();
			end
			step();
		end

		//======================================================================
		// DIP writes mixed with other indices and addresses
		//======================================================================
		for (int i = 0; i < 400; i++) begin
			r = rand32();
			s = rand32();
			random_pads(2'(i / 16));
			ioctl_wr = r[0] | r[1];
			ioctl_index = r[2] ? `IH_IDX_DIP : r[15:8];
			if (ioctl_index == `IH_IDX_HEADER) begin
				ioctl_index = 8'd2;
			end
			ioctl_addr = (s[1:0] == 2'b00) ? s[31:7] : {22'd0, s[4:2]};
			ioctl_dout = r[23:16];
			step();
		end
		ioctl_wr = 1'b0;

		// Rate changes with random stalls
		pll_window = 1'b1;
		repeat (8) pll_change();
		pll_window = 1'b0;
		repeat (5) step();

		total = ctrl_errors + flag_errors + dip_errors + pll_errors + timeouts;
		$display("Checks %0d, errors ctrl %0d flags %0d dip %0d pll %0d timeouts %0d",
			checks, ctrl_errors, flag_errors, dip_errors, pll_errors, timeouts);
		if (total == 0) begin
			$display("SIMULATION PASSED");
		end else begin
			$display("SIMULATION FAILED");
		end
		$finish;
	end

endmodule

// ==== ih_inputs.f ====
+incdir+design
design/ih_pkg.sv
design/ih_ifaces.sv
design/ps2_button_decoder.sv
design/rom_option_capture.sv
design/joystick_router.sv
design/pll_rate_sequencer.sv
design/ih_input_top.sv
sim/tb_ih_inputs.sv

// ==== Makefile ====
TOP = tb_ih_inputs

.PHONY: sim clean

sim:
	verilator --binary --timing --assert --top-module $(TOP) -f ih_inputs.f
	out=$$(./obj_dir/V$(TOP)); \
	echo "$$out"; \
	echo "$$out" | grep -q "^SIMULATION PASSED$$"

clean:
	rm -rf obj_dir
